//--- hdl/fetch_requester.sv
// ----------------------------------------------------------
// Fetch requester
// Fetch FSM, memory request address and tracking of reads
// in flight, including stale reads to be discarded
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_requester import ifu_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    new_pc_req,
    input  wire logic [XLEN-1:0]         new_pc,
    input  wire logic                    stop_fetch,
    input  wire logic                    imem_ack,
    input  wire mem_resp_e               resp_code,
    input  wire logic [Q_FREE_W_W-1:0]   q_free_words,
    output logic                         imem_req,
    output logic [XLEN-1:0]              imem_addr,
    output logic                         resp_keep,
    output logic                         ifu_busy
);

    fetch_state_e          state;
    logic [XLEN-1:2]       addr_r;
    logic [XLEN-1:2]       addr_base;
    logic [TXN_CNT_W-1:0]  txn_cnt;          // Accepted, not yet answered
    logic [TXN_CNT_W-1:0]  discard_cnt;
    logic [TXN_CNT_W-1:0]  discard_cnt_next;
    logic [TXN_CNT_W-1:0]  vd_txn_cnt;
    logic                  txn_full;
    logic                  discard;
    logic                  req_acc;
    logic                  resp_any;
    logic                  err_kept;

    assign resp_any   = (resp_code == RESP_OK) | (resp_code == RESP_ERR);
    assign discard    = |discard_cnt;
    assign resp_keep  = resp_any & ~discard;
    assign err_kept   = resp_keep & (resp_code == RESP_ERR);
    assign txn_full   = &txn_cnt;
    assign vd_txn_cnt = txn_cnt - discard_cnt;   // Reads whose data will be kept

    // ------------------------------------------------------
    // Memory request
    // ------------------------------------------------------
    assign imem_req = (new_pc_req & ~txn_full)
                    | ((state == FETCH_ACTIVE) & ~txn_full
                       & (TXN_CNT_W'(q_free_words) > vd_txn_cnt));

    assign req_acc   = imem_req & imem_ack;
    assign addr_base = new_pc_req ? new_pc[XLEN-1:2] : addr_r;
    assign imem_addr = {addr_base, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_r <= '0;
        end else if (req_acc) begin
            addr_r <= addr_base + 1'b1;          // Next word
        end else if (new_pc_req) begin
            addr_r <= new_pc[XLEN-1:2];
        end
    end

    // ------------------------------------------------------
    // In-flight and discard counters
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_cnt <= '0;
        end else begin
            case ({req_acc, resp_any})
                2'b10:   txn_cnt <= txn_cnt + 1'b1;
                2'b01:   txn_cnt <= txn_cnt - 1'b1;
                default: txn_cnt <= txn_cnt;     // None or both
            endcase
        end
    end

    always_comb begin
        discard_cnt_next = discard_cnt;
        if (new_pc_req) begin
            // Everything still out belongs to the old stream
            discard_cnt_next = txn_cnt - TXN_CNT_W'(resp_any);
        end else if (err_kept) begin
            discard_cnt_next = req_acc ? txn_cnt : txn_cnt - 1'b1;  // All reads left over
        end else if (resp_any & discard) begin
            discard_cnt_next = discard_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            discard_cnt <= '0;
        end else begin
            discard_cnt <= discard_cnt_next;
        end
    end

    // ------------------------------------------------------
    // Fetch FSM
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_IDLE;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (new_pc_req & ~stop_fetch) begin
                        state <= FETCH_ACTIVE;
                    end
                end
                FETCH_ACTIVE: begin
                    if (stop_fetch | (err_kept & ~new_pc_req)) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    assign ifu_busy = (state == FETCH_ACTIVE);

    a_discard_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        discard_cnt <= txn_cnt
    ) else $error("Discard counter exceeds reads in flight");

    a_addr_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_req |-> (imem_addr[1:0] == 2'b00)
    ) else $error("Unaligned instruction memory request");

endmodule

`default_nettype wire

//--- hdl/ifu_pkg.sv
// ----------------------------------------------------------
// Instruction fetch unit shared definitions
// Widths, queue sizing, enums and bus structs
// ----------------------------------------------------------
`default_nettype none

package ifu_pkg;

    // ------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int IMEM_DWIDTH = 32;
    localparam int HWORD_W     = IMEM_DWIDTH / 2;

    localparam int Q_SIZE_HALF = 4;                          // Queue depth in halfwords
    localparam int Q_SIZE_WORD = Q_SIZE_HALF / 2;
    localparam int Q_ADR_W     = $clog2(Q_SIZE_HALF);
    localparam int Q_PTR_W     = Q_ADR_W + 1;                // Extra bit tells full from empty
    localparam int Q_OCPD_W    = $clog2(Q_SIZE_HALF + 1);
    localparam int Q_FREE_W_W  = $clog2(Q_SIZE_WORD + 1);    // Free word count

    localparam int TXN_CNT_W   = 3;                          // Full at all ones

    // ------------------------------------------------------
    // Enums
    // ------------------------------------------------------
    typedef enum logic {
        FETCH_IDLE,
        FETCH_ACTIVE
    } fetch_state_e;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_OK,
        RESP_ERR
    } mem_resp_e;

    typedef enum logic [1:0] {
        WE_NONE,
        WE_FULL,                                             // Both halves of rdata
        WE_HI                                                // Upper half only
    } q_we_e;

    // Named as <upper half>_<lower half> of the response data
    typedef enum logic [2:0] {
        NONE,
        RVI_HI_RVI_LO,
        RVC_RVC,
        RVI_LO_RVC,
        RVC_RVI_HI,
        RVI_LO_RVI_HI,
        RVC_NV,                                              // Lower half skipped
        RVI_LO_NV
    } rdata_ident_e;

    // ------------------------------------------------------
    // Structs
    // ------------------------------------------------------
    typedef struct packed {
        mem_resp_e              code;
        logic [IMEM_DWIDTH-1:0] rdata;
    } imem_resp_s;

    typedef struct packed {
        q_we_e                  we;
        logic [IMEM_DWIDTH-1:0] data;
        logic                   err;
    } q_wr_s;

    typedef struct packed {
        logic [IMEM_DWIDTH-1:0] instr;                       // RVC is zero-extended
        logic                   imem_err;
        logic                   err_rvi_hi;
    } ifu_instr_s;

endpackage

`default_nettype wire

//--- hdl/ifu_top.sv
// ----------------------------------------------------------
// Instruction fetch unit top level
// Connects requester, classifier and queue to the memory
// and decoder ports
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ifu_top import ifu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // Instruction memory
    output logic                   imem_req,
    output logic [XLEN-1:0]        imem_addr,
    input  wire logic              imem_ack,
    input  wire imem_resp_s        imem_resp,
    // Control
    input  wire logic              new_pc_req,
    input  wire logic [XLEN-1:0]   new_pc,
    input  wire logic              stop_fetch,
    output logic                   ifu_busy,
    // Decoder
    output logic                   instr_valid,
    output ifu_instr_s             instr,
    input  wire logic              instr_ready
);

    logic                   resp_keep;
    logic                   q_flush;
    logic [Q_FREE_W_W-1:0]  q_free_words;
    q_wr_s                  q_wr;

    assign q_flush = new_pc_req | stop_fetch;     // Old stream is dropped

    fetch_requester u_requester (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_ack     (imem_ack),
        .resp_code    (imem_resp.code),
        .q_free_words (q_free_words),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .resp_keep    (resp_keep),
        .ifu_busy     (ifu_busy)
    );

    resp_classifier u_classifier (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_pc_req (new_pc_req),
        .new_pc_hw  (new_pc[1]),
        .resp       (imem_resp),
        .resp_keep  (resp_keep),
        .q_wr       (q_wr)
    );

    instr_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (q_flush),
        .q_wr         (q_wr),
        .instr_ready  (instr_ready),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .q_free_words (q_free_words)
    );

endmodule

`default_nettype wire

//--- hdl/instr_queue.sv
// ----------------------------------------------------------
// Instruction queue
// Halfword queue that rebuilds RVC/RVI instructions and
// hands them to the decoder with their fault flags
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instr_queue import ifu_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   flush,
    input  wire q_wr_s                  q_wr,
    input  wire logic                   instr_ready,
    output logic                        instr_valid,
    output ifu_instr_s                  instr,
    output logic [Q_FREE_W_W-1:0]       q_free_words
);

    logic [HWORD_W-1:0]   q_data [Q_SIZE_HALF];
    logic                 q_err  [Q_SIZE_HALF];

    logic [Q_PTR_W-1:0]   q_rptr;
    logic [Q_PTR_W-1:0]   q_rptr_next;
    logic [Q_PTR_W-1:0]   q_wptr;
    logic [Q_ADR_W-1:0]   rd_idx0;
    logic [Q_ADR_W-1:0]   rd_idx1;
    logic [Q_ADR_W-1:0]   wr_idx0;
    logic [Q_ADR_W-1:0]   wr_idx1;
    logic [Q_OCPD_W-1:0]  q_ocpd;
    logic [Q_OCPD_W-1:0]  q_ocpd_rd;        // Occupancy after this cycle's read
    logic [Q_OCPD_W-1:0]  q_free_h;
    logic [1:0]           rd_step;
    logic [1:0]           wr_step;
    logic                 q_empty;

    logic [HWORD_W-1:0]   data_head;
    logic [HWORD_W-1:0]   data_next;
    logic                 err_head;
    logic                 err_next;
    logic                 head_rvi;

    // ------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------
    assign rd_idx0 = q_rptr[Q_ADR_W-1:0];
    assign rd_idx1 = rd_idx0 + 1'b1;
    assign wr_idx0 = q_wptr[Q_ADR_W-1:0];
    assign wr_idx1 = wr_idx0 + 1'b1;

    assign q_empty = (q_rptr == q_wptr);
    assign q_ocpd  = Q_OCPD_W'(q_wptr - q_rptr);

    always_comb begin
        rd_step = 2'd0;
        if (instr_valid & instr_ready) begin
            rd_step = (~head_rvi | err_head) ? 2'd1 : 2'd2;
        end
    end

    always_comb begin
        case (q_wr.we)
            WE_FULL: wr_step = 2'd2;
            WE_HI:   wr_step = 2'd1;
            default: wr_step = 2'd0;
        endcase
    end

    assign q_rptr_next  = q_rptr + Q_PTR_W'(rd_step);
    assign q_ocpd_rd    = Q_OCPD_W'(q_wptr - q_rptr_next);
    assign q_free_h     = Q_OCPD_W'(Q_SIZE_HALF) - q_ocpd_rd;
    assign q_free_words = Q_FREE_W_W'(q_free_h >> 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_rptr <= '0;
            q_wptr <= '0;
        end else if (flush) begin
            q_rptr <= '0;
            q_wptr <= '0;
        end else begin
            q_rptr <= q_rptr_next;
            q_wptr <= q_wptr + Q_PTR_W'(wr_step);
        end
    end

    // ------------------------------------------------------
    // Storage
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!flush) begin
            case (q_wr.we)
                WE_HI: begin
                    q_data[wr_idx0] <= q_wr.data[IMEM_DWIDTH-1:HWORD_W];
                    q_err[wr_idx0]  <= q_wr.err;
                end
                WE_FULL: begin
                    q_data[wr_idx0] <= q_wr.data[HWORD_W-1:0];
                    q_err[wr_idx0]  <= q_wr.err;
                    q_data[wr_idx1] <= q_wr.data[IMEM_DWIDTH-1:HWORD_W];
                    q_err[wr_idx1]  <= q_wr.err;
                end
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------
    // Decoder side
    // ------------------------------------------------------
    assign data_head = q_data[rd_idx0];
    assign data_next = q_data[rd_idx1];
    assign err_head  = q_err[rd_idx0];
    assign err_next  = q_err[rd_idx1];
    assign head_rvi  = &data_head[1:0];

    always_comb begin
        instr_valid      = 1'b0;
        instr.imem_err   = 1'b0;
        instr.err_rvi_hi = 1'b0;
        if (!q_empty) begin
            if (q_ocpd == Q_OCPD_W'(1)) begin
                instr_valid    = ~head_rvi | err_head;    // RVI waits for its tail
                instr.imem_err = err_head;
            end else begin
                instr_valid      = 1'b1;
                instr.imem_err   = err_head | (head_rvi & err_next);
                instr.err_rvi_hi = ~err_head & head_rvi & err_next;
            end
        end
    end

    assign instr.instr = head_rvi ? {data_next, data_head} : IMEM_DWIDTH'(data_head);

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!flush && q_wr.we != WE_NONE) |-> (q_ocpd_rd + wr_step <= Q_SIZE_HALF)
    ) else $error("Instruction queue overflow");

    a_rvi_hi_fault: assert property (
        @(posedge clk) disable iff (!rst_n)
        (instr_valid && instr.err_rvi_hi) |-> instr.imem_err
    ) else $error("Upper-half fault without access fault");

endmodule

`default_nettype wire

//--- hdl/resp_classifier.sv
// ----------------------------------------------------------
// Response classifier
// Sorts each kept response into RVC/RVI halves and builds
// the matching queue write
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module resp_classifier import ifu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        new_pc_req,
    input  wire logic        new_pc_hw,
    input  wire imem_resp_s  resp,
    input  wire logic        resp_keep,
    output q_wr_s            q_wr
);

    logic          rvi_part2;          // Next lower half is the tail of an RVI
    logic          rvi_part2_next;
    logic          unaligned;          // Skip lower half of first response
    logic          resp_ok;
    logic          resp_err;
    logic          hi_rvi;
    logic          lo_rvi;
    rdata_ident_e  ident;

    assign resp_ok  = resp.code == RESP_OK;
    assign resp_err = resp.code == RESP_ERR;
    assign hi_rvi   = &resp.rdata[HWORD_W+1:HWORD_W];
    assign lo_rvi   = &resp.rdata[1:0];

    always_comb begin
        ident = NONE;
        if (resp_keep & resp_ok) begin
            if (unaligned) begin
                ident = hi_rvi ? RVI_LO_NV : RVC_NV;
            end else if (rvi_part2) begin
                ident = hi_rvi ? RVI_LO_RVI_HI : RVC_RVI_HI;
            end else if (lo_rvi) begin
                ident = RVI_HI_RVI_LO;
            end else begin
                ident = hi_rvi ? RVI_LO_RVC : RVC_RVC;
            end
        end
    end

    assign rvi_part2_next = (ident == RVI_LO_NV) | (ident == RVI_LO_RVI_HI)
                          | (ident == RVI_LO_RVC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvi_part2 <= 1'b0;
            unaligned <= 1'b0;
        end else if (new_pc_req) begin
            rvi_part2 <= 1'b0;
            unaligned <= new_pc_hw;
        end else if (resp_keep) begin
            rvi_part2 <= rvi_part2_next;
            unaligned <= 1'b0;
        end
    end

    // Queue write
    always_comb begin
        q_wr.we = WE_NONE;
        if (resp_keep & resp_err) begin
            q_wr.we = WE_FULL;                 // Both halves carry the fault
        end else begin
            case (ident)
                NONE:              q_wr.we = WE_NONE;
                RVC_NV, RVI_LO_NV: q_wr.we = WE_HI;
                default:           q_wr.we = WE_FULL;
            endcase
        end
    end

    assign q_wr.data = resp.rdata;
    assign q_wr.err  = resp_err;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f vlog.f --top-module tb_ifu -Mdir obj_dir; then
    echo "Compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ifu)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -q "Testbench passed"; then
    exit 0
fi
exit 1

//--- test/tb_ifu_ref.svh
// ----------------------------------------------------------
// Instruction fetch testbench reference model
// Memory image, expected instruction stream and checking
// ----------------------------------------------------------
`ifndef TB_IFU_REF_SVH
`define TB_IFU_REF_SVH

localparam int ERR_WORD = 96;                 // Word at byte address 0x180 answers RESP_ERR

// ----------------------------------------------------------
// Memory image
// ----------------------------------------------------------
// One halfword per address, RVI heads spread by the index
function automatic logic [15:0] img_hw(input logic [31:0] addr);
    logic [7:0] idx;
    logic [1:0] low;
    int         k;
    idx = addr[8:1] ^ addr[16:9];
    k   = int'(addr[8:1]);
    if (((k * 7) % 5) < 2) begin
        low = 2'b11;                          // RVI head
    end else begin
        low = 2'(k % 3);
    end
    return {idx ^ 8'h5a, idx[5:0], low};
endfunction

function automatic bit in_err_word(input logic [31:0] addr);
    return addr[31:2] == 30'(ERR_WORD);
endfunction

// ----------------------------------------------------------
// Reference instruction stream
// ----------------------------------------------------------
// Error words read back as zero data
function automatic ifu_instr_s ref_entry(input logic [31:0] pc, output int step);
    ifu_instr_s e;
    logic [15:0] h0;
    logic [15:0] h1;
    h0 = img_hw(pc);
    h1 = img_hw(pc + 32'd2);
    e  = '0;
    step = 1;
    if (in_err_word(pc)) begin
        e.imem_err = 1'b1;                    // Faulted head stands alone
    end else if (h0[1:0] == 2'b11) begin
        step = 2;
        if (in_err_word(pc + 32'd2)) begin
            e.instr      = {16'h0000, h0};
            e.imem_err   = 1'b1;
            e.err_rvi_hi = 1'b1;
        end else begin
            e.instr = {h1, h0};
        end
    end else begin
        e.instr = {16'h0000, h0};
    end
    return e;
endfunction

// Fills the expected queue; ends once the error word is used up
task automatic load_expected(input logic [31:0] start_pc, input int max_n);
    logic [31:0] pc;
    ifu_instr_s  e;
    int          step;
    pc = start_pc;
    for (int i = 0; i < max_n; i++) begin
        e  = ref_entry(pc, step);
        pc = pc + 32'(2 * step);
        exp_q.push_back(e);
        if (e.imem_err && !in_err_word(pc)) begin
            break;
        end
    end
endtask

// ----------------------------------------------------------
// Checking
// ----------------------------------------------------------
task automatic fail_run(input string why);
    $display("ERROR: %s", why);
    $display("Testbench failed");
    $fatal(1, "Stopping at first error");
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        fail_run("Wrong value seen");
    end
endtask

`endif

//--- test/tb_ifu.sv
// ----------------------------------------------------------
// Instruction fetch unit testbench
// Memory model, decoder side checker and directed tests
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ifu import ifu_pkg::*; ();

    localparam int TOTAL_INSTR   = 212;       // Sum of all stream lengths
    localparam int CYC_PER_INSTR = 30;
    localparam int RDY_RAND = 0;
    localparam int RDY_LOW  = 1;
    localparam int RDY_HIGH = 2;

    logic        clk;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_ack;
    imem_resp_s  imem_resp;
    logic        new_pc_req;
    logic [31:0] new_pc;
    logic        stop_fetch;
    logic        ifu_busy;
    logic        instr_valid;
    ifu_instr_s  instr;
    logic        instr_ready;

    ifu_instr_s  exp_q[$];
    logic [31:0] pend_addr[$];
    int          pend_due[$];
    int          cyc;
    int          ready_mode;

    `include "tb_ifu_ref.svh"

    ifu_top u_ifu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_ack    (imem_ack),
        .imem_resp   (imem_resp),
        .new_pc_req  (new_pc_req),
        .new_pc      (new_pc),
        .stop_fetch  (stop_fetch),
        .ifu_busy    (ifu_busy),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------
    // Memory model
    // ------------------------------------------------------
    initial begin : mem_model
        logic [31:0] a;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
            if (rst_n && imem_req && imem_ack) begin
                pend_addr.push_back(imem_addr);
                pend_due.push_back(cyc + int'($urandom_range(0, 3)));
            end
            #1;
            imem_ack  = rst_n && (($urandom % 4) != 0);
            imem_resp = '0;
            if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
                a = pend_addr.pop_front();
                void'(pend_due.pop_front());
                if (in_err_word(a)) begin
                    imem_resp.code = RESP_ERR;     // Data stays zero
                end else begin
                    imem_resp.code  = RESP_OK;
                    imem_resp.rdata = {img_hw(a + 32'd2), img_hw(a)};
                end
            end
        end
    end

    // Decoder ready stays low once nothing more is expected
    initial begin : ready_drv
        forever begin
            @(posedge clk);
            #2;
            case (ready_mode)
                RDY_LOW:  instr_ready = 1'b0;
                RDY_HIGH: instr_ready = 1'b1;
                default:  instr_ready = (exp_q.size() > 0) && (($urandom % 3) != 0);
            endcase
        end
    end

    // ------------------------------------------------------
    // Checker
    // ------------------------------------------------------
    initial begin : compare
        ifu_instr_s e;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (imem_req) begin
                    check_val("imem_addr[1:0]", 32'(imem_addr[1:0]), 32'h0);
                end
                if (instr_valid && instr_ready) begin
                    if (exp_q.size() == 0) begin
                        fail_run("Instruction delivered when none was expected");
                    end else begin
                        e = exp_q.pop_front();
                        check_val("instr.instr", instr.instr, e.instr);
                        check_val("instr.imem_err", 32'(instr.imem_err), 32'(e.imem_err));
                        check_val("instr.err_rvi_hi", 32'(instr.err_rvi_hi),
                                  32'(e.err_rvi_hi));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #((TOTAL_INSTR * CYC_PER_INSTR + 500) * 100);
        fail_run("Watchdog expired, the run is hung");
    end

    // ------------------------------------------------------
    // Test tasks
    // ------------------------------------------------------
    task automatic redirect(input logic [31:0] pc, input int n);
        @(posedge clk);
        #1;
        ready_mode = RDY_LOW;                     // No transfer in the redirect cycle
        new_pc_req = 1'b1;
        new_pc     = pc;
        exp_q.delete();
        load_expected(pc, n);
        @(posedge clk);
        #1;
        new_pc_req = 1'b0;
        ready_mode = RDY_RAND;
        check_val("ifu_busy", 32'(ifu_busy), 32'h1);
    endtask

    task automatic wait_left(input int left);
        int n;
        n = 0;
        while (exp_q.size() > left) begin
            @(posedge clk);
            n = n + 1;
            if (n > TOTAL_INSTR * CYC_PER_INSTR / 4) begin
                fail_run("Expected instructions were not delivered in time");
            end
        end
    endtask

    task automatic quiet_window(input int ncyc);
        ready_mode = RDY_HIGH;                    // Any transfer now is an error
        repeat (ncyc) @(posedge clk);
        #1;
        ready_mode = RDY_LOW;
    endtask

    task automatic drain_memory();
        int calm;
        int n;
        calm = 0;
        n = 0;
        ready_mode = RDY_LOW;
        while (calm < 3) begin
            @(posedge clk);
            calm = (pend_addr.size() == 0 && !imem_req) ? calm + 1 : 0;
            n = n + 1;
            if (n > 200) begin
                fail_run("Reads in flight never drained");
            end
        end
    endtask

    function automatic logic [31:0] find_head(input bit want_rvi, input logic [31:0] from);
        logic [31:0] pc;
        logic [15:0] h;
        pc = {from[31:2], 2'b10};
        for (int k = 0; k < 64; k++) begin
            h = img_hw(pc);
            if ((h[1:0] == 2'b11) == want_rvi) begin
                return pc;
            end
            pc = pc + 32'd4;
        end
        return pc;
    endfunction

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------
    initial begin : main
        void'($urandom(32'h22ba));
        rst_n       = 1'b0;
        imem_ack    = 1'b0;
        imem_resp   = '0;
        new_pc_req  = 1'b0;
        new_pc      = '0;
        stop_fetch  = 1'b0;
        instr_ready = 1'b0;
        ready_mode  = RDY_LOW;
        cyc         = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_val("ifu_busy", 32'(ifu_busy), 32'h0);

        redirect(32'h0000_0000, 30);              // Aligned mixed stream
        wait_left(0);
        redirect(find_head(1'b1, 32'h40), 16);    // Halfword PC on an RVI
        wait_left(0);
        redirect(find_head(1'b0, 32'h60), 16);    // Halfword PC on an RVC
        wait_left(0);

        redirect(32'h0000_0100, 30);              // Redirect with reads in flight
        wait_left(25);
        redirect(32'h0000_0040, 20);
        wait_left(0);

        redirect(32'(ERR_WORD * 4 - 10), 40);     // Runs into the error word
        wait_left(0);
        quiet_window(20);
        check_val("ifu_busy", 32'(ifu_busy), 32'h0);

        redirect(32'h0000_0020, 40);              // Stop part way
        wait_left(32);
        drain_memory();
        @(posedge clk);
        #1;
        stop_fetch = 1'b1;
        exp_q.delete();
        @(posedge clk);
        #1;
        stop_fetch = 1'b0;
        check_val("ifu_busy", 32'(ifu_busy), 32'h0);
        quiet_window(20);

        redirect(32'h0000_0008, 20);
        wait_left(0);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+test
hdl/ifu_pkg.sv
hdl/fetch_requester.sv
hdl/resp_classifier.sv
hdl/instr_queue.sv
hdl/ifu_top.sv
test/tb_ifu.sv
